// File: ipv4_checksum_verify.f
design/ipv4_chk_pkg.sv
design/ipv4_header_serializer.sv
design/hdr_word_fifo.sv
design/ipv4_checksum_checker.sv
design/ipv4_checksum_verify.sv
sim/ipv4_checksum_verify_tb.sv

// File: Makefile
# Verilator build, run and lint for the IPv4 checksum verify project

VERILATOR ?= verilator
TB_TOP    ?= ipv4_checksum_verify_tb
RTL_TOP   ?= ipv4_checksum_verify
FILELIST  ?= ipv4_checksum_verify.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(shell grep '^design/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/ipv4_checksum_verify_tb.sv
/* IPv4 checksum verify testbench */

`timescale 1ns/100ps

module ipv4_checksum_verify_tb;

    import ipv4_chk_pkg::*;

    localparam int NUM_ROWS    = 14;
    localparam int HOLD_ROW    = 6;
    localparam int RANDOM_ROW  = 10;
    localparam int HOLD_CYCLES = 40;
    localparam int TIMEOUT     = 500;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] ident;
        logic [2:0]  flags;
        logic [12:0] frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [15:0] chksum;
        logic [31:0] src;
        logic [31:0] dst;
        logic        corrupt;
        logic        exp_ok;
    } row_t;

    logic        clk;
    logic        reset;
    logic        req;
    logic        req_ready;
    logic        result_valid;
    logic        result_ready;
    logic        chksum_valid;
    logic [5:0]  ip_dscp;
    logic [1:0]  ip_ecn;
    logic [2:0]  ip_flags;
    logic [12:0] ip_fragment_offset;
    logic [7:0]  ip_ttl;
    logic [7:0]  ip_protocol;
    logic [15:0] ip_length;
    logic [15:0] ip_identification;
    logic [15:0] ip_hdr_chksum;
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;

    row_t   rows [NUM_ROWS];
    string  names [NUM_ROWS];
    integer seed;
    int     errors;
    int     checks;
    logic   hung;

    ipv4_checksum_verify u_ipv4_checksum_verify (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Reference model and checking

    // RFC 1071 style sum over the header with the checksum word zeroed
    function automatic logic [15:0] ref_checksum(input row_t r);
        logic [15:0] words [HDR_WORDS];
        logic [31:0] acc;
        int          k;
        words[0] = {IP_VERSION, IP_IHL, r.dscp, r.ecn};
        words[1] = r.length;
        words[2] = r.ident;
        words[3] = {r.flags, r.frag};
        words[4] = {r.ttl, r.proto};
        words[5] = 16'h0000;
        words[6] = r.src[31:16];
        words[7] = r.src[15:0];
        words[8] = r.dst[31:16];
        words[9] = r.dst[15:0];
        acc = '0;
        for (k = 0; k < HDR_WORDS; k++) begin
            acc = acc + 32'(words[k]);
        end
        acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        return ~acc[15:0];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        hung = 1'b1;
        $display("Timeout: no progress while waiting for %s at %0t", what, $time);
    endtask

    ////////////////////////////////////////
    // Stimulus table

    task automatic fill_table();
        row_t        r;
        logic [31:0] rnd;
        int          i;
        // Textbook header 4500 0073 0000 4000 4011 b861 c0a8 0001 c0a8 00c7
        r = '{6'd0, 2'd0, 16'h0073, 16'h0000, 3'b010, 13'd0, 8'h40, 8'h11, 16'hB861,
              32'hC0A8_0001, 32'hC0A8_00C7, 1'b0, 1'b1};
        rows[0]  = r;
        names[0] = "textbook";
        // All ones makes the sum carry out on almost every word
        r = '1;
        r.corrupt = 1'b0;
        r.chksum  = ref_checksum(r);
        rows[1]   = r;
        names[1]  = "all_ones";
        for (i = 2; i < NUM_ROWS; i++) begin
            rnd       = $random(seed);
            r.dscp    = rnd[5:0];
            r.ecn     = rnd[7:6];
            r.length  = rnd[31:16];
            rnd       = $random(seed);
            r.ident   = rnd[15:0];
            r.flags   = rnd[18:16];
            r.frag    = rnd[31:19];
            rnd       = $random(seed);
            r.ttl     = rnd[7:0];
            r.proto   = rnd[15:8];
            r.corrupt = rnd[16] || (i == 2);
            r.src     = $random(seed);
            r.dst     = $random(seed);
            r.exp_ok  = !r.corrupt;
            // Off by one is never a valid one's complement checksum here
            r.chksum  = ref_checksum(r) + 16'(r.corrupt);
            rows[i]   = r;
            names[i]  = $sformatf("row%0d", i);
        end
    endtask

    task automatic drive_row(input row_t r);
        ip_dscp            <= r.dscp;
        ip_ecn             <= r.ecn;
        ip_length          <= r.length;
        ip_identification  <= r.ident;
        ip_flags           <= r.flags;
        ip_fragment_offset <= r.frag;
        ip_ttl             <= r.ttl;
        ip_protocol        <= r.proto;
        ip_hdr_chksum      <= r.chksum;
        ip_source_ip       <= r.src;
        ip_dest_ip         <= r.dst;
    endtask

    ////////////////////////////////////////
    // Request and result processes

    task automatic send_all();
        int i;
        int waited;
        for (i = 0; i < NUM_ROWS; i++) begin
            drive_row(rows[i]);
            req    <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!req_ready && waited < TIMEOUT && !hung);
            if (!req_ready && !hung) begin
                report_timeout($sformatf("request %s", names[i]));
            end
        end
        req <= 1'b0;
    endtask

    task automatic collect_row(input int i, input logic random_ready);
        int          waited;
        logic        taken;
        logic [31:0] rnd;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < TIMEOUT && !hung) begin
            @(posedge clk);
            waited++;
            rnd = $random(seed);
            if (result_valid && result_ready) begin
                taken = 1'b1;
            end else begin
                result_ready <= random_ready ? rnd[0] : 1'b1;
            end
        end
        if (taken) begin
            compare_value(names[i], 32'(rows[i].exp_ok), 32'(chksum_valid));
        end else if (!hung) begin
            report_timeout($sformatf("result %s", names[i]));
        end
    endtask

    // Stall the result port long enough for the FIFO and producer to back up
    task automatic hold_results();
        int   waited;
        int   k;
        logic seen;
        logic held_flag;
        waited = 0;
        seen   = 1'b0;
        result_ready <= 1'b0;
        while (!seen && waited < TIMEOUT && !hung) begin
            @(posedge clk);
            waited++;
            seen = result_valid;
        end
        if (!seen) begin
            if (!hung) begin
                report_timeout("held result");
            end
        end else begin
            held_flag = chksum_valid;
            for (k = 0; k < HOLD_CYCLES; k++) begin
                @(posedge clk);
                compare_value("hold_result_valid", 32'd1, 32'(result_valid));
                compare_value("hold_chksum_stable", 32'(held_flag), 32'(chksum_valid));
            end
            compare_value("hold_req_stall", 32'd0, 32'(req_ready));
        end
    endtask

    task automatic collect_all();
        int i;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (i == HOLD_ROW) begin
                hold_results();
            end
            collect_row(i, i >= RANDOM_ROW);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        clk    = 1'b0;
        seed   = 32'h1693;
        errors = 0;
        checks = 0;
        hung   = 1'b0;
        fill_table();
        reset        <= 1'b1;
        req          <= 1'b0;
        result_ready <= 1'b1;
        drive_row(rows[0]);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare_value("reset_req_ready", 32'd1, 32'(req_ready));
        compare_value("reset_result_valid", 32'd0, 32'(result_valid));
        compare_value("textbook_reference", 32'h0000_B861, 32'(ref_checksum(rows[0])));
        fork
            send_all();
            collect_all();
        join
        // No further result may appear once every header is accounted for
        result_ready <= 1'b1;
        repeat (30) begin
            @(posedge clk);
            compare_value("no_extra_result", 32'd0, 32'(result_valid));
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: design/ipv4_checksum_verify.sv
/* IPv4 checksum verify top level */

`timescale 1ns/100ps

module ipv4_checksum_verify #(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_WIDTH = 17
) (
    input  logic        clk,
    input  logic        reset,
    // Header request
    input  logic        req,
    output logic        req_ready,
    input  logic [5:0]  ip_dscp,
    input  logic [1:0]  ip_ecn,
    input  logic [15:0] ip_length,
    input  logic [15:0] ip_identification,
    input  logic [2:0]  ip_flags,
    input  logic [12:0] ip_fragment_offset,
    input  logic [7:0]  ip_ttl,
    input  logic [7:0]  ip_protocol,
    input  logic [15:0] ip_hdr_chksum,
    input  logic [31:0] ip_source_ip,
    input  logic [31:0] ip_dest_ip,
    // Result
    output logic        result_valid,
    input  logic        result_ready,
    output logic        chksum_valid
);

    import ipv4_chk_pkg::*;

    ////////////////////////////////////////
    // Internal streams

    // Producer to FIFO
    logic                  wr_valid;
    logic                  wr_ready;
    hdr_word_t             wr_word;
    logic                  wr_last;

    // FIFO to checker with {last, word} entries
    logic                  rd_valid;
    logic                  rd_ready;
    logic [FIFO_WIDTH-1:0] rd_data;

    ////////////////////////////////////////
    // Blocks

    ipv4_header_serializer u_serializer (
        .clk                (clk),
        .reset              (reset),
        .req                (req),
        .req_ready          (req_ready),
        .ip_dscp            (ip_dscp),
        .ip_ecn             (ip_ecn),
        .ip_length          (ip_length),
        .ip_identification  (ip_identification),
        .ip_flags           (ip_flags),
        .ip_fragment_offset (ip_fragment_offset),
        .ip_ttl             (ip_ttl),
        .ip_protocol        (ip_protocol),
        .ip_hdr_chksum      (ip_hdr_chksum),
        .ip_source_ip       (ip_source_ip),
        .ip_dest_ip         (ip_dest_ip),
        .wr_valid           (wr_valid),
        .wr_ready           (wr_ready),
        .wr_word            (wr_word),
        .wr_last            (wr_last)
    );

    hdr_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_WIDTH (FIFO_WIDTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_data  ({wr_last, wr_word}),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_data  (rd_data)
    );

    ipv4_checksum_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_word      (rd_data[$bits(hdr_word_t)-1:0]),
        .rd_last      (rd_data[FIFO_WIDTH-1]),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .chksum_valid (chksum_valid)
    );

endmodule

// File: design/ipv4_checksum_checker.sv
/* IPv4 checksum checker */

`timescale 1ns/100ps

module ipv4_checksum_checker (
    input  logic                    clk,
    input  logic                    reset,
    // Word stream from the FIFO
    input  logic                    rd_valid,
    output logic                    rd_ready,
    input  ipv4_chk_pkg::hdr_word_t rd_word,
    input  logic                    rd_last,
    // Result
    output logic                    result_valid,
    input  logic                    result_ready,
    output logic                    chksum_valid
);

    import ipv4_chk_pkg::*;

    typedef enum logic {
        S_SUM,
        S_HOLD
    } state_t;

    state_t      state;
    hdr_word_t   sum_q;
    hdr_word_t   sum_next;
    logic [16:0] add_full;
    logic        word_taken;

    ////////////////////////////////////////
    // One's complement adder

    // Carry out of bit 15 wraps back into bit 0
    assign add_full = {1'b0, sum_q} + {1'b0, rd_word};
    assign sum_next = add_full[15:0] + hdr_word_t'(add_full[16]);

    ////////////////////////////////////////
    // Control

    assign rd_ready     = (state == S_SUM);
    assign result_valid = (state == S_HOLD);
    assign word_taken   = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_SUM;
            sum_q        <= '0;
            chksum_valid <= 1'b0;
        end else begin
            case (state)
                S_SUM: begin
                    if (word_taken) begin
                        sum_q <= sum_next;
                        if (rd_last) begin
                            chksum_valid <= (sum_next == CHK_GOOD);
                            state        <= S_HOLD;
                        end
                    end
                end
                S_HOLD: begin
                    // Flag is held until the result is accepted
                    if (result_ready) begin
                        sum_q        <= '0;
                        chksum_valid <= 1'b0;
                        state        <= S_SUM;
                    end
                end
                default: state <= S_SUM;
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks

    a_no_overlap: assert property (
        @(posedge clk) disable iff (reset)
        !(rd_ready && result_valid)
    );

    a_result_hold: assert property (
        @(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(chksum_valid)
    );

endmodule

// File: design/hdr_word_fifo.sv
/* Header word FIFO */

`timescale 1ns/100ps

module hdr_word_fifo #(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_WIDTH = 17
) (
    input  logic                  clk,
    input  logic                  reset,
    // Write side
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic [FIFO_WIDTH-1:0] wr_data,
    // Read side
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic [FIFO_WIDTH-1:0] rd_data
);

    // Depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  wr_en;
    logic                  rd_en;

    ////////////////////////////////////////
    // Flow control

    assign wr_ready = (count != CNT_W'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head entry comes straight from the storage flops
    assign rd_data = mem[rd_ptr];

    ////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= CNT_W'(FIFO_DEPTH)
    );

    // Empty with nothing written means nothing can be popped next cycle
    a_no_empty_read: assert property (
        @(posedge clk) disable iff (reset)
        (count == '0) && !wr_en |=> !rd_en
    );

endmodule

// File: design/ipv4_header_serializer.sv
/* IPv4 header serializer */

`timescale 1ns/100ps

module ipv4_header_serializer (
    input  logic                    clk,
    input  logic                    reset,
    // Header request
    input  logic                    req,
    output logic                    req_ready,
    input  logic [5:0]              ip_dscp,
    input  logic [1:0]              ip_ecn,
    input  logic [15:0]             ip_length,
    input  logic [15:0]             ip_identification,
    input  logic [2:0]              ip_flags,
    input  logic [12:0]             ip_fragment_offset,
    input  logic [7:0]              ip_ttl,
    input  logic [7:0]              ip_protocol,
    input  logic [15:0]             ip_hdr_chksum,
    input  logic [31:0]             ip_source_ip,
    input  logic [31:0]             ip_dest_ip,
    // Word stream toward the FIFO
    output logic                    wr_valid,
    input  logic                    wr_ready,
    output ipv4_chk_pkg::hdr_word_t wr_word,
    output logic                    wr_last
);

    import ipv4_chk_pkg::*;

    localparam int               IDX_W    = $clog2(HDR_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(HDR_WORDS - 1);

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] word_idx;
    logic             word_taken;

    // Latched header fields
    logic [5:0]  dscp_q;
    logic [1:0]  ecn_q;
    logic [15:0] length_q;
    logic [15:0] ident_q;
    logic [2:0]  flags_q;
    logic [12:0] frag_q;
    logic [7:0]  ttl_q;
    logic [7:0]  proto_q;
    logic [15:0] chksum_q;
    logic [31:0] src_q;
    logic [31:0] dst_q;

    ////////////////////////////////////////
    // Control

    assign req_ready  = (state == S_IDLE);
    assign wr_valid   = (state == S_SEND);
    assign wr_last    = wr_valid && (word_idx == LAST_IDX);
    assign word_taken = wr_valid && wr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state    <= S_SEND;
                        word_idx <= '0;
                    end
                end
                S_SEND: begin
                    if (word_taken) begin
                        if (wr_last) begin
                            state    <= S_IDLE;
                            word_idx <= '0;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Fields are captured only on an accepted request
    always_ff @(posedge clk) begin
        if (req && req_ready) begin
            dscp_q   <= ip_dscp;
            ecn_q    <= ip_ecn;
            length_q <= ip_length;
            ident_q  <= ip_identification;
            flags_q  <= ip_flags;
            frag_q   <= ip_fragment_offset;
            ttl_q    <= ip_ttl;
            proto_q  <= ip_protocol;
            chksum_q <= ip_hdr_chksum;
            src_q    <= ip_source_ip;
            dst_q    <= ip_dest_ip;
        end
    end

    ////////////////////////////////////////
    // Word select in wire order

    always_comb begin
        case (word_idx)
            IDX_W'(0): wr_word = {IP_VERSION, IP_IHL, dscp_q, ecn_q};
            IDX_W'(1): wr_word = length_q;
            IDX_W'(2): wr_word = ident_q;
            IDX_W'(3): wr_word = {flags_q, frag_q};
            IDX_W'(4): wr_word = {ttl_q, proto_q};
            IDX_W'(5): wr_word = chksum_q;
            IDX_W'(6): wr_word = src_q[31:16];
            IDX_W'(7): wr_word = src_q[15:0];
            IDX_W'(8): wr_word = dst_q[31:16];
            default:   wr_word = dst_q[15:0];
        endcase
    end

    // A stalled word stays offered and unchanged
    a_word_hold: assert property (
        @(posedge clk) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_word) && $stable(wr_last)
    );

endmodule

// File: design/ipv4_chk_pkg.sv
/* IPv4 header checksum definitions */

package ipv4_chk_pkg;

    ////////////////////////////////////////
    // Header layout

    // Option-less IPv4 header is ten 16-bit words
    localparam int HDR_WORDS = 10;

    // Fixed version and header length nibbles
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL     = 4'd5;

    ////////////////////////////////////////
    // Word type and check value

    typedef logic [15:0] hdr_word_t;

    // One's complement sum over a header with a correct checksum
    localparam hdr_word_t CHK_GOOD = 16'hFFFF;

endpackage
